//--- dv/icache_properties.sv
// Bound assertions on the CPU and bus four-phase handshakes
`timescale 1ns/1ps

module icache_properties (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic ack_o,
  input logic error_o,
  input logic biu_req_o,
  input logic biu_ack_i
);

  int fail_cnt = 0;  // Read by the testbench

  // ------------------------------------------------
  // CPU side
  // ------------------------------------------------
  ack_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ack_o && req_i |=> ack_o)
    else begin $error("ack_o fell while req_i was high"); fail_cnt++; end

  error_qual_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !ack_o |-> !error_o)
    else begin $error("error_o high without ack_o"); fail_cnt++; end

  // ------------------------------------------------
  // Bus side
  // ------------------------------------------------
  biu_req_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    biu_req_o && !biu_ack_i |=> biu_req_o)
    else begin $error("biu_req_o dropped before biu_ack_i"); fail_cnt++; end

  // Request rises on the edge after ack was seen low
  biu_req_rise_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(biu_req_o) |-> !$past(biu_ack_i))
    else begin $error("biu_req_o rose while biu_ack_i high"); fail_cnt++; end

endmodule

//--- dv/tb_icache.sv
// Instruction cache testbench with bus memory model, directed and random reads,
// reference checks and final verdict
`timescale 1ns/1ps

module tb_icache;

  import icache_cfg_pkg::*;
  import biu_pkg::*;

  localparam int    TIMEOUT = 200;             // Cycles per wait
  localparam word_t REF_KEY = 32'h3C5A_96E1;

  logic       clk_i = 1'b0;
  logic       rst_ni;
  logic       req_i;
  adr_t       adr_i;
  logic       invalidate_i;
  logic       ack_o;
  word_t      data_o;
  logic       error_o;
  logic       biu_req_o;
  adr_t       biu_adr_o;
  logic       biu_ack_i = 1'b0;
  word_t      biu_q_i   = '0;
  logic       biu_err_i = 1'b0;
  adr_t       err_adr   = '1;                  // Unaligned, matches no beat
  logic       exp_err   = 1'b0;
  logic       req_seen  = 1'b0;
  logic       ack_seen  = 1'b0;
  int         mem_delay = 0;
  int         bus_reqs  = 0;
  int         n_reads   = 0;
  int         n_resp    = 0;
  int         n_checks  = 0;
  int         n_errors  = 0;
  logic [7:0] mem_lfsr  = 8'd80;
  logic [7:0] stim_lfsr = 8'd80;

  always #2 clk_i = ~clk_i;

  icache_top icache_top_inst (.*);

  bind icache_top icache_properties icache_properties_inst (
    .clk_i(clk_i), .rst_ni(rst_ni), .req_i(req_i), .ack_o(ack_o), .error_o(error_o),
    .biu_req_o(biu_req_o), .biu_ack_i(biu_ack_i)
  );

  // ------------------------------------------------
  // Reference model and helpers
  // ------------------------------------------------
  function automatic word_t ref_word(adr_t adr);
    return word_t'(adr >> 2) ^ REF_KEY;         // Word address XOR key
  endfunction

  function automatic logic [7:0] lfsr_next(logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  task automatic draw_bits(inout logic [7:0] state, input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsr_next(state);                 // One step per bit
      val   = {val[30:0], state[0]};
    end
  endtask

  task automatic check_word(string name, word_t got, word_t exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    n_checks++;
    if (got != exp) begin
      n_errors++;
      $display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic stop_on_timeout(string what);
    $display("ERROR: timed out waiting for %s", what);
    $display(">>> FAIL");
    $finish;
  endtask

  // ------------------------------------------------
  // Bus memory model
  // ------------------------------------------------
  always @(negedge clk_i) begin
    logic [31:0] rnd;
    if (!rst_ni) begin
      biu_ack_i <= 1'b0;
      biu_err_i <= 1'b0;
      req_seen  = 1'b0;
    end else begin
      if (biu_req_o && !req_seen) begin
        bus_reqs++;
        draw_bits(mem_lfsr, 2, rnd);
        mem_delay = int'(rnd[1:0]);             // 0 to 3 cycles
      end
      req_seen = biu_req_o;
      if (biu_req_o && !biu_ack_i) begin
        if (mem_delay == 0) begin
          biu_ack_i <= 1'b1;
          biu_q_i   <= ref_word(biu_adr_o);
          biu_err_i <= (biu_adr_o == err_adr);
        end else begin
          mem_delay--;
        end
      end else if (!biu_req_o && biu_ack_i) begin
        biu_ack_i <= 1'b0;
        biu_err_i <= 1'b0;
      end
    end
  end

  // Compare each response when ack_o first shows up
  always @(negedge clk_i) begin
    if (rst_ni && ack_o && !ack_seen) begin
      check_word("data_o", data_o, exp_err ? '0 : ref_word(adr_i));
      check_flag("error_o", error_o, exp_err);
      n_resp++;
    end
    ack_seen = ack_o;
  end

  // ------------------------------------------------
  // Stimulus
  // ------------------------------------------------
  task automatic wait_ack(logic level, string what);
    int waited;
    waited = 0;
    while (ack_o !== level) begin
      if (waited == TIMEOUT) stop_on_timeout(what);
      @(negedge clk_i);
      waited++;
    end
  endtask

  task automatic read_word(adr_t adr, logic err_expected);
    exp_err = err_expected;
    adr_i   = adr;
    req_i   = 1'b1;
    n_reads++;
    @(negedge clk_i);
    wait_ack(1'b1, "ack_o to rise");
    req_i = 1'b0;                               // Release, ack drops next cycle
    wait_ack(1'b0, "ack_o to fall");
  endtask

  initial begin
    logic [31:0] rnd;
    int          base;
    int          n_asrt;
    req_i        = 1'b0;
    adr_i        = '0;
    invalidate_i = 1'b0;
    rst_ni       = 1'b0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Cold miss fills one block
    base = bus_reqs;
    read_word(32'h0000_0048, 1'b0);
    check_count("bus requests on cold miss", bus_reqs - base, BURST_LEN);

    // Rest of that block hits
    base = bus_reqs;
    read_word(32'h0000_0040, 1'b0);
    read_word(32'h0000_0044, 1'b0);
    read_word(32'h0000_004C, 1'b0);
    check_count("bus requests on block hits", bus_reqs - base, 0);

    // Two blocks in set 2, both ways used
    read_word(32'h0000_0120, 1'b0);
    read_word(32'h0000_2120, 1'b0);
    base = bus_reqs;
    for (int i = 0; i < 4; i++) begin
      read_word(32'h0000_0120 + adr_t'(4 * i), 1'b0);
      read_word(32'h0000_2120 + adr_t'(4 * i), 1'b0);
    end
    check_count("bus requests on shared index", bus_reqs - base, 0);

    // Invalidate all, then refetch
    invalidate_i = 1'b1;
    @(negedge clk_i);
    invalidate_i = 1'b0;
    base = bus_reqs;
    read_word(32'h0000_0048, 1'b0);
    check_count("bus requests after invalidate", bus_reqs - base, BURST_LEN);

    // Bus error on word 2 of block 0x300
    err_adr = 32'h0000_0308;
    read_word(32'h0000_0304, 1'b1);
    err_adr = '1;
    base = bus_reqs;
    read_word(32'h0000_0304, 1'b0);
    if (bus_reqs - base < 1) begin
      n_errors++;
      $display("ERROR: failed block was not fetched again after the bus error");
    end

    // Random reads over a 2 KiB window
    repeat (200) begin
      draw_bits(stim_lfsr, 9, rnd);
      read_word({21'b0, rnd[8:0], 2'b00}, 1'b0);
    end
    check_count("responses", n_resp, n_reads);

    n_asrt = icache_top_inst.icache_properties_inst.fail_cnt;
    $display("Checks: %0d  Errors: %0d  Assertion failures: %0d", n_checks, n_errors, n_asrt);
    if (n_errors == 0 && n_asrt == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- rtl/biu_pkg.sv
// Bus-side burst constants, beat counter and refill states
package biu_pkg;

  localparam int BURST_LEN  = 4;                           // Beats per block
  localparam int BEAT_BYTES = icache_cfg_pkg::XLEN / 8;

  // Low address bits cleared to form the block base
  localparam int BURST_OFFS_BITS = $clog2(BURST_LEN * BEAT_BYTES);

  typedef logic [$clog2(BURST_LEN)-1:0] beat_t;

  localparam beat_t LAST_BEAT = beat_t'(BURST_LEN - 1);

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_REQUEST,   // biu_req_o high, waiting for ack
    RF_RELEASE,   // biu_req_o low, waiting for ack to drop
    RF_DONE
  } refill_state_t;

endpackage

//--- rtl/icache_cfg_pkg.sv
// Instruction cache geometry, address field types and helpers,
// and the fetch front-end state encoding
package icache_cfg_pkg;

  // ------------------------------------------------
  // Geometry
  // ------------------------------------------------
  localparam int XLEN        = 32;
  localparam int WAYS        = 2;
  localparam int SETS        = 8;
  localparam int BLOCK_WORDS = 4;                         // Words per block

  localparam int BYTE_BITS = $clog2(XLEN / 8);            // Byte offset in a word
  localparam int OFFS_BITS = $clog2(BLOCK_WORDS);         // Word offset in a block
  localparam int IDX_BITS  = $clog2(SETS);
  localparam int TAG_BITS  = XLEN - IDX_BITS - OFFS_BITS - BYTE_BITS;

  typedef logic [XLEN-1:0]             adr_t;
  typedef logic [XLEN-1:0]             word_t;
  typedef logic [BLOCK_WORDS*XLEN-1:0] line_t;             // Word 0 in the low bits
  typedef logic [IDX_BITS-1:0]         idx_t;
  typedef logic [TAG_BITS-1:0]         tag_t;
  typedef logic [OFFS_BITS-1:0]        offs_t;
  typedef logic [WAYS-1:0]             way_t;              // One-hot

  typedef enum logic [1:0] {
    FE_IDLE,
    FE_LOOKUP,
    FE_REFILL,
    FE_RESPOND
  } fe_state_t;

  // ------------------------------------------------
  // Address field extraction
  // ------------------------------------------------
  function automatic idx_t adr_idx(adr_t adr);
    return adr[BYTE_BITS+OFFS_BITS +: IDX_BITS];
  endfunction

  function automatic tag_t adr_tag(adr_t adr);
    return adr[XLEN-1 -: TAG_BITS];
  endfunction

  function automatic offs_t adr_offs(adr_t adr);
    return adr[BYTE_BITS +: OFFS_BITS];
  endfunction

  function automatic word_t line_word(line_t line, offs_t offs);
    return line[offs*XLEN +: XLEN];
  endfunction

endpackage

//--- rtl/icache_frontend.sv
// CPU-side fetch FSM, merges lookup and refill results into the response
`timescale 1ns/1ps

module icache_frontend (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  icache_cfg_pkg::adr_t  adr_i,
  output logic                  ack_o,
  output icache_cfg_pkg::word_t data_o,
  output logic                  error_o,
  output logic                  rd_en_o,
  input  logic                  hit_i,
  input  icache_cfg_pkg::line_t line_i,
  output logic                  wr_en_o,
  output logic                  refill_start_o,
  input  logic                  refill_done_i,
  input  logic                  refill_err_i,
  input  icache_cfg_pkg::line_t refill_line_i
);

  import icache_cfg_pkg::*;

  fe_state_t state_q;
  logic      resp_err_q;
  offs_t     word_offs;

  assign word_offs = adr_offs(adr_i);

  // ------------------------------------------------
  // Array and refill control
  // ------------------------------------------------
  assign rd_en_o        = (state_q == FE_IDLE) && req_i;
  assign refill_start_o = (state_q == FE_LOOKUP) && !hit_i;   // One cycle, state moves on

  // Failed refills never reach the array
  assign wr_en_o = (state_q == FE_REFILL) && refill_done_i && !refill_err_i;

  // ------------------------------------------------
  // Handshake FSM
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= FE_IDLE;
      ack_o      <= 1'b0;
      error_o    <= 1'b0;
      resp_err_q <= 1'b0;
    end else begin
      unique case (state_q)
        FE_IDLE: begin
          if (req_i) state_q <= FE_LOOKUP;             // Array read issued this cycle
        end
        FE_LOOKUP: begin
          resp_err_q <= 1'b0;
          state_q    <= hit_i ? FE_RESPOND : FE_REFILL;
        end
        FE_REFILL: begin
          if (refill_done_i) begin
            resp_err_q <= refill_err_i;
            state_q    <= FE_RESPOND;
          end
        end
        FE_RESPOND: begin
          if (!ack_o) begin
            ack_o   <= 1'b1;
            error_o <= resp_err_q;
          end else if (!req_i) begin
            // CPU released, drop ack and go back for the next request
            ack_o   <= 1'b0;
            error_o <= 1'b0;
            state_q <= FE_IDLE;
          end
        end
        default: state_q <= FE_IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // Response word
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (state_q == FE_LOOKUP && hit_i) begin
      data_o <= line_word(line_i, word_offs);
    end else if (state_q == FE_REFILL && refill_done_i) begin
      data_o <= refill_err_i ? '0 : line_word(refill_line_i, word_offs);
    end
  end

endmodule

//--- rtl/icache_lookup.sv
// Set-associative tag, valid and data arrays with registered hit detection
// and LFSR based fill-way selection
`timescale 1ns/1ps

module icache_lookup (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rd_en_i,
  input  icache_cfg_pkg::adr_t  rd_adr_i,
  output logic                  hit_o,
  output icache_cfg_pkg::line_t line_o,
  input  logic                  wr_en_i,
  input  icache_cfg_pkg::adr_t  wr_adr_i,
  input  icache_cfg_pkg::line_t wr_line_i,
  input  logic                  invalidate_i
);

  import icache_cfg_pkg::*;

  tag_t            tag_q   [WAYS][SETS];
  line_t           data_q  [WAYS][SETS];
  logic [SETS-1:0] valid_q [WAYS];

  logic [6:0] lfsr_q;
  idx_t       rd_idx;
  idx_t       wr_idx;
  way_t       ways_hit;
  way_t       fill_way;
  line_t      hit_line;

  assign rd_idx = adr_idx(rd_adr_i);
  assign wr_idx = adr_idx(wr_adr_i);

  // ------------------------------------------------
  // Read side
  // ------------------------------------------------
  always_comb begin
    ways_hit = '0;
    hit_line = '0;
    for (int w = 0; w < WAYS; w++) begin
      ways_hit[w] = valid_q[w][rd_idx] && (tag_q[w][rd_idx] == adr_tag(rd_adr_i));
      if (ways_hit[w]) begin
        hit_line = hit_line | data_q[w][rd_idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hit_o <= 1'b0;
    end else if (rd_en_i) begin
      hit_o <= |ways_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      line_o <= hit_line;
    end
  end

  // ------------------------------------------------
  // Way replacement
  // ------------------------------------------------
  // Free-running XNOR LFSR, frozen during a line write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= '0;
    end else if (!wr_en_i) begin
      lfsr_q <= {lfsr_q[5:0], lfsr_q[6] ~^ lfsr_q[5]};
    end
  end

  always_comb begin
    fill_way = '0;
    for (int w = WAYS - 1; w >= 0; w--) begin
      if (!valid_q[w][wr_idx]) fill_way = way_t'(1) << w;  // Lowest invalid way wins
    end
    if (fill_way == '0) begin
      fill_way = way_t'(1) << lfsr_q[$clog2(WAYS)-1:0];    // Set full, pick at random
    end
  end

  // ------------------------------------------------
  // Write side
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < WAYS; w++) valid_q[w] <= '0;
    end else if (invalidate_i) begin
      for (int w = 0; w < WAYS; w++) valid_q[w] <= '0;      // Invalidate all
    end else if (wr_en_i) begin
      for (int w = 0; w < WAYS; w++) begin
        if (fill_way[w]) valid_q[w][wr_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      for (int w = 0; w < WAYS; w++) begin
        if (fill_way[w]) begin
          tag_q[w][wr_idx]  <= adr_tag(wr_adr_i);
          data_q[w][wr_idx] <= wr_line_i;
        end
      end
    end
  end

endmodule

//--- rtl/icache_refill.sv
// Block refill engine, one 4-beat burst over the four-phase bus
`timescale 1ns/1ps

module icache_refill (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  start_i,
  input  icache_cfg_pkg::adr_t  base_adr_i,
  output logic                  done_o,
  output logic                  err_o,
  output icache_cfg_pkg::line_t line_o,
  output logic                  biu_req_o,
  output icache_cfg_pkg::adr_t  biu_adr_o,
  input  logic                  biu_ack_i,
  input  icache_cfg_pkg::word_t biu_q_i,
  input  logic                  biu_err_i
);

  import icache_cfg_pkg::*;
  import biu_pkg::*;

  refill_state_t state_q;
  beat_t         beat_q;
  logic          err_q;
  adr_t          base_q;
  line_t         line_q;

  assign biu_req_o = (state_q == RF_REQUEST);
  assign biu_adr_o = base_q + adr_t'(beat_q) * adr_t'(BEAT_BYTES);  // Word 0 first
  assign done_o    = (state_q == RF_DONE);
  assign err_o     = err_q;
  assign line_o    = line_q;

  // ------------------------------------------------
  // Beat sequencing
  // ------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RF_IDLE;
      beat_q  <= '0;
      err_q   <= 1'b0;
    end else begin
      unique case (state_q)
        RF_IDLE: begin
          if (start_i) begin
            beat_q  <= '0;
            err_q   <= 1'b0;
            state_q <= RF_REQUEST;
          end
        end
        RF_REQUEST: begin
          if (biu_ack_i) begin
            err_q   <= biu_err_i;
            state_q <= RF_RELEASE;
          end
        end
        RF_RELEASE: begin
          // Next beat only once memory has dropped its ack
          if (!biu_ack_i) begin
            if (err_q || beat_q == LAST_BEAT) begin
              state_q <= RF_DONE;                          // Stop early on error
            end else begin
              beat_q  <= beat_q + 1'b1;
              state_q <= RF_REQUEST;
            end
          end
        end
        RF_DONE: state_q <= RF_IDLE;
        default: state_q <= RF_IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // Address and line buffer
  // ------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (state_q == RF_IDLE && start_i) begin
      base_q <= base_adr_i;
    end
    if (state_q == RF_REQUEST && biu_ack_i) begin
      line_q[beat_q*XLEN +: XLEN] <= biu_q_i;               // Word lands at its offset
    end
  end

endmodule

//--- rtl/icache_top.sv
// Instruction cache top level, connects lookup, refill and front end
`timescale 1ns/1ps

module icache_top (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  req_i,
  input  icache_cfg_pkg::adr_t  adr_i,
  output logic                  ack_o,
  output icache_cfg_pkg::word_t data_o,
  output logic                  error_o,
  input  logic                  invalidate_i,
  output logic                  biu_req_o,
  output icache_cfg_pkg::adr_t  biu_adr_o,
  input  logic                  biu_ack_i,
  input  icache_cfg_pkg::word_t biu_q_i,
  input  logic                  biu_err_i
);

  import icache_cfg_pkg::*;
  import biu_pkg::*;

  logic  rd_en;
  logic  hit;
  logic  wr_en;
  logic  refill_start;
  logic  refill_done;
  logic  refill_err;
  line_t lookup_line;
  line_t refill_line;
  adr_t  block_adr;

  assign block_adr = {adr_i[XLEN-1:BURST_OFFS_BITS], {BURST_OFFS_BITS{1'b0}}};

  // ------------------------------------------------
  // Array lookup
  // ------------------------------------------------
  icache_lookup icache_lookup_inst (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .rd_en_i      ( rd_en        ),
    .rd_adr_i     ( adr_i        ),
    .hit_o        ( hit          ),
    .line_o       ( lookup_line  ),
    .wr_en_i      ( wr_en        ),
    .wr_adr_i     ( adr_i        ),
    .wr_line_i    ( refill_line  ),
    .invalidate_i ( invalidate_i )
  );

  // ------------------------------------------------
  // Refill engine
  // ------------------------------------------------
  icache_refill icache_refill_inst (
    .clk_i      ( clk_i        ),
    .rst_ni     ( rst_ni       ),
    .start_i    ( refill_start ),
    .base_adr_i ( block_adr    ),
    .done_o     ( refill_done  ),
    .err_o      ( refill_err   ),
    .line_o     ( refill_line  ),
    .biu_req_o  ( biu_req_o    ),
    .biu_adr_o  ( biu_adr_o    ),
    .biu_ack_i  ( biu_ack_i    ),
    .biu_q_i    ( biu_q_i      ),
    .biu_err_i  ( biu_err_i    )
  );

  // ------------------------------------------------
  // Fetch front end
  // ------------------------------------------------
  icache_frontend icache_frontend_inst (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .req_i          ( req_i        ),
    .adr_i          ( adr_i        ),
    .ack_o          ( ack_o        ),
    .data_o         ( data_o       ),
    .error_o        ( error_o      ),
    .rd_en_o        ( rd_en        ),
    .hit_i          ( hit          ),
    .line_i         ( lookup_line  ),
    .wr_en_o        ( wr_en        ),
    .refill_start_o ( refill_start ),
    .refill_done_i  ( refill_done  ),
    .refill_err_i   ( refill_err   ),
    .refill_line_i  ( refill_line  )
  );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the instruction cache testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_icache -f verilog.f -o sim_icache
./obj_dir/sim_icache +verilator+error+limit+1000 2>&1 | tee sim.log

if grep -q ">>> FAIL" sim.log; then
  exit 1
fi
exit 0

//--- verilog.f
rtl/icache_cfg_pkg.sv
rtl/biu_pkg.sv
rtl/icache_lookup.sv
rtl/icache_refill.sv
rtl/icache_frontend.sv
rtl/icache_top.sv
dv/icache_properties.sv
dv/tb_icache.sv
